// File: source/pci_master_pkg.sv
package pci_master_pkg;

	// axi read channel field widths
	localparam int ID_W = 4;
	localparam int LEN_W = 8; // beats minus one
	localparam int ADDR_W = 64;
	localparam int DATA_W = 32;
	localparam int RESP_W = 2;

	// axi response codes
	localparam logic [RESP_W-1:0] RESP_OKAY = 2'd0;
	localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

	// command fifo entry is {id, len, addr}
	localparam int CMD_WORD_W = ID_W + LEN_W + ADDR_W;

	// response fifo entry is {status, id, len}
	localparam int RESP_WORD_W = RESP_W + ID_W + LEN_W;

endpackage

// File: source/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int AW = 4
) (
	input  logic             clk,
	input  logic             mst_s_aresetn,
	input  logic [WIDTH-1:0] din,
	input  logic             wr_en,
	output logic             full,
	output logic             almost_full,
	output logic [WIDTH-1:0] dout,
	input  logic             rd_en,
	output logic             empty
);

	localparam int DEPTH = 1 << AW;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	assign full = (count == (AW+1)'(DEPTH));
	assign almost_full = (count >= (AW+1)'(DEPTH-1)); // one free slot or none
	assign empty = (count == '0);
	assign dout = mem[rd_ptr]; // fwft so the head word is always on dout

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	a_no_write_full: assert property (
		@(posedge clk) disable iff (!mst_s_aresetn)
		!(wr_en && full)
	) else $error("sync_fifo: write while full");

	a_no_read_empty: assert property (
		@(posedge clk) disable iff (!mst_s_aresetn)
		!(rd_en && empty)
	) else $error("sync_fifo: read while empty");

endmodule

// File: source/pci_read_sequencer.sv
`timescale 1ns/1ns

module pci_read_sequencer (
	input  logic                              clk,
	input  logic                              mst_s_aresetn,

	input  logic [pci_master_pkg::ID_W-1:0]   cmd_id,
	input  logic [pci_master_pkg::LEN_W-1:0]  cmd_len,
	input  logic [pci_master_pkg::ADDR_W-1:0] cmd_addr,
	input  logic                              cmd_valid,
	output logic                              cmd_ready,

	output logic [pci_master_pkg::DATA_W-1:0] data_din,
	output logic                              data_valid,
	input  logic                              data_ready,

	output logic [pci_master_pkg::ID_W-1:0]   resp_id,
	output logic [pci_master_pkg::LEN_W-1:0]  resp_len,
	output logic [pci_master_pkg::RESP_W-1:0] resp_err,
	output logic                              resp_valid,
	input  logic                              resp_ready,

	output logic [pci_master_pkg::ADDR_W-1:0] tgt_addr,
	output logic                              tgt_req,
	input  logic                              tgt_ack,
	input  logic [pci_master_pkg::DATA_W-1:0] tgt_rdata,
	input  logic                              tgt_err
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ = 2'd1;
	localparam logic [1:0] ST_DATA = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0] state;
	logic [pci_master_pkg::ID_W-1:0] id_q;
	logic [pci_master_pkg::LEN_W-1:0] len_q;
	logic [pci_master_pkg::ADDR_W-1:0] addr_q;
	logic [pci_master_pkg::DATA_W-1:0] data_q;
	logic [pci_master_pkg::LEN_W-1:0] beat_cnt;
	logic err_q;
	logic cmd_fire;
	logic data_fire;
	logic last_beat;

	assign cmd_ready = (state == ST_IDLE); // one burst at a time
	assign cmd_fire = cmd_valid && cmd_ready;
	assign data_fire = data_valid && data_ready;
	assign last_beat = (beat_cnt == len_q);

	assign tgt_req = (state == ST_REQ);
	assign tgt_addr = addr_q;

	assign data_valid = (state == ST_DATA);
	assign data_din = data_q;

	assign resp_valid = (state == ST_RESP);
	assign resp_id = id_q;
	assign resp_len = len_q;
	assign resp_err = err_q ? pci_master_pkg::RESP_SLVERR : pci_master_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			id_q <= cmd_id;
			len_q <= cmd_len;
			addr_q <= cmd_addr;
		end else if (data_fire && !last_beat) begin
			addr_q <= addr_q + 64'd4; // next dword
		end
		if (tgt_req && tgt_ack)
			data_q <= tgt_rdata;
	end

	always_ff @(posedge clk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			state <= ST_IDLE;
			beat_cnt <= '0;
			err_q <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_fire) begin
						beat_cnt <= '0;
						err_q <= 1'b0;
						state <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (tgt_ack) begin
						err_q <= err_q || tgt_err; // sticky over the burst
						state <= ST_DATA;
					end
				end
				ST_DATA: begin
					if (data_fire) begin
						if (last_beat) begin
							state <= ST_RESP;
						end else begin
							beat_cnt <= beat_cnt + 1'b1;
							state <= ST_REQ;
						end
					end
				end
				default: begin
					if (resp_ready)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	a_tgt_req_held: assert property (
		@(posedge clk) disable iff (!mst_s_aresetn)
		(tgt_req && !tgt_ack) |=> (tgt_req && $stable(tgt_addr))
	) else $error("pci_read_sequencer: tgt_req or tgt_addr changed before ack");

	a_data_held: assert property (
		@(posedge clk) disable iff (!mst_s_aresetn)
		(data_valid && !data_ready) |=> (data_valid && $stable(data_din))
	) else $error("pci_read_sequencer: data word dropped before it was taken");

endmodule

// File: source/pci_master_rpath.sv
`timescale 1ns/1ns

module pci_master_rpath #(
	parameter int CMD_AW = 4,
	parameter int DATA_AW = 6
) (
	input  logic                             clk,
	input  logic                             mst_s_aresetn,

	input  logic [pci_master_pkg::ID_W-1:0]   mst_s_arid,
	input  logic [pci_master_pkg::ADDR_W-1:0] mst_s_araddr,
	input  logic [pci_master_pkg::LEN_W-1:0]  mst_s_arlen,
	input  logic [2:0]                        mst_s_arsize,
	input  logic [1:0]                        mst_s_arburst,
	input  logic [3:0]                        mst_s_arcache,
	input  logic                              mst_s_arvalid,
	output logic                              mst_s_arready,

	output logic [pci_master_pkg::ID_W-1:0]   mst_s_rid,
	output logic [pci_master_pkg::DATA_W-1:0] mst_s_rdata,
	output logic [pci_master_pkg::RESP_W-1:0] mst_s_rresp,
	output logic                              mst_s_rlast,
	output logic                              mst_s_rvalid,
	input  logic                              mst_s_rready,

	output logic [pci_master_pkg::ID_W-1:0]   cmd_id,
	output logic [pci_master_pkg::LEN_W-1:0]  cmd_len,
	output logic [pci_master_pkg::ADDR_W-1:0] cmd_addr,
	output logic                              cmd_valid,
	input  logic                              cmd_ready,

	input  logic [pci_master_pkg::ID_W-1:0]   resp_id,
	input  logic [pci_master_pkg::LEN_W-1:0]  resp_len,
	input  logic [pci_master_pkg::RESP_W-1:0] resp_err,
	input  logic                              resp_valid,
	output logic                              resp_ready,

	input  logic [pci_master_pkg::DATA_W-1:0] data_din,
	input  logic                              data_valid,
	output logic                              data_ready
);

	logic cmd_full;
	logic cmd_empty;
	logic cmd_wr;
	logic cmd_rd;
	logic [pci_master_pkg::CMD_WORD_W-1:0] cmd_word;

	logic [pci_master_pkg::DATA_W-1:0] data_q;
	logic data_wr;
	logic data_afull;
	logic data_empty;
	logic data_rd;

	logic resp_full;
	logic resp_empty;
	logic resp_wr;
	logic resp_rd;
	logic [pci_master_pkg::RESP_WORD_W-1:0] resp_word;
	logic [pci_master_pkg::RESP_W-1:0] r_err;
	logic [pci_master_pkg::LEN_W-1:0] r_len;

	logic [pci_master_pkg::LEN_W-1:0] beat_cnt;
	logic beat_fire;

	assign mst_s_arready = !cmd_full;
	assign cmd_wr = mst_s_arvalid && mst_s_arready;
	assign cmd_valid = !cmd_empty;
	assign cmd_rd = cmd_valid && cmd_ready;
	assign {cmd_id, cmd_len, cmd_addr} = cmd_word;

	// keep a slot free for the word sitting in data_q
	assign data_ready = !data_afull;
	assign resp_ready = !resp_full;
	assign resp_wr = resp_valid && resp_ready;

	// status only arrives after the whole burst, so beats wait for it
	assign mst_s_rvalid = !data_empty && !resp_empty;
	assign {r_err, mst_s_rid, r_len} = resp_word;
	assign mst_s_rresp = r_err;
	assign mst_s_rlast = (beat_cnt == r_len);
	assign beat_fire = mst_s_rvalid && mst_s_rready;
	assign data_rd = beat_fire;
	assign resp_rd = beat_fire && mst_s_rlast;

	always_ff @(posedge clk) begin
		data_q <= data_din;
	end

	always_ff @(posedge clk or negedge mst_s_aresetn) begin
		if (!mst_s_aresetn) begin
			data_wr <= 1'b0;
			beat_cnt <= '0;
		end else begin
			data_wr <= data_valid && data_ready;
			if (beat_fire)
				beat_cnt <= mst_s_rlast ? '0 : beat_cnt + 1'b1;
		end
	end

	sync_fifo #(.WIDTH(pci_master_pkg::CMD_WORD_W), .AW(CMD_AW)) cmd_fifo_i (
		.clk(clk),
		.mst_s_aresetn(mst_s_aresetn),
		.din({mst_s_arid, mst_s_arlen, mst_s_araddr}), // size, burst, cache dropped
		.wr_en(cmd_wr),
		.full(cmd_full),
		.almost_full(),
		.dout(cmd_word),
		.rd_en(cmd_rd),
		.empty(cmd_empty)
	);

	sync_fifo #(.WIDTH(pci_master_pkg::DATA_W), .AW(DATA_AW)) data_fifo_i (
		.clk(clk),
		.mst_s_aresetn(mst_s_aresetn),
		.din(data_q),
		.wr_en(data_wr),
		.full(),
		.almost_full(data_afull),
		.dout(mst_s_rdata),
		.rd_en(data_rd),
		.empty(data_empty)
	);

	sync_fifo #(.WIDTH(pci_master_pkg::RESP_WORD_W), .AW(CMD_AW)) resp_fifo_i (
		.clk(clk),
		.mst_s_aresetn(mst_s_aresetn),
		.din({resp_err, resp_id, resp_len}),
		.wr_en(resp_wr),
		.full(resp_full),
		.almost_full(),
		.dout(resp_word),
		.rd_en(resp_rd),
		.empty(resp_empty)
	);

	// status lands with or after its last word, so its beats are buffered
	a_resp_has_data: assert property (
		@(posedge clk) disable iff (!mst_s_aresetn)
		!resp_empty |-> !data_empty
	) else $error("pci_master_rpath: burst status queued ahead of its data");

endmodule

// File: source/pci_master_read_top.sv
`timescale 1ns/1ns

module pci_master_read_top #(
	parameter int CMD_AW = 4,
	parameter int DATA_AW = 6
) (
	input  logic                              clk,
	input  logic                              mst_s_aresetn,

	input  logic [pci_master_pkg::ID_W-1:0]   mst_s_arid,
	input  logic [pci_master_pkg::ADDR_W-1:0] mst_s_araddr,
	input  logic [pci_master_pkg::LEN_W-1:0]  mst_s_arlen,
	input  logic [2:0]                        mst_s_arsize,
	input  logic [1:0]                        mst_s_arburst,
	input  logic [3:0]                        mst_s_arcache,
	input  logic                              mst_s_arvalid,
	output logic                              mst_s_arready,

	output logic [pci_master_pkg::ID_W-1:0]   mst_s_rid,
	output logic [pci_master_pkg::DATA_W-1:0] mst_s_rdata,
	output logic [pci_master_pkg::RESP_W-1:0] mst_s_rresp,
	output logic                              mst_s_rlast,
	output logic                              mst_s_rvalid,
	input  logic                              mst_s_rready,

	output logic [pci_master_pkg::ADDR_W-1:0] tgt_addr,
	output logic                              tgt_req,
	input  logic                              tgt_ack,
	input  logic [pci_master_pkg::DATA_W-1:0] tgt_rdata,
	input  logic                              tgt_err
);

	logic [pci_master_pkg::ID_W-1:0] cmd_id;
	logic [pci_master_pkg::LEN_W-1:0] cmd_len;
	logic [pci_master_pkg::ADDR_W-1:0] cmd_addr;
	logic cmd_valid;
	logic cmd_ready;

	logic [pci_master_pkg::DATA_W-1:0] data_din;
	logic data_valid;
	logic data_ready;

	logic [pci_master_pkg::ID_W-1:0] resp_id;
	logic [pci_master_pkg::LEN_W-1:0] resp_len;
	logic [pci_master_pkg::RESP_W-1:0] resp_err;
	logic resp_valid;
	logic resp_ready;

	pci_master_rpath #(.CMD_AW(CMD_AW), .DATA_AW(DATA_AW)) rpath_i (
		.clk(clk),
		.mst_s_aresetn(mst_s_aresetn),
		.mst_s_arid(mst_s_arid),
		.mst_s_araddr(mst_s_araddr),
		.mst_s_arlen(mst_s_arlen),
		.mst_s_arsize(mst_s_arsize),
		.mst_s_arburst(mst_s_arburst),
		.mst_s_arcache(mst_s_arcache),
		.mst_s_arvalid(mst_s_arvalid),
		.mst_s_arready(mst_s_arready),
		.mst_s_rid(mst_s_rid),
		.mst_s_rdata(mst_s_rdata),
		.mst_s_rresp(mst_s_rresp),
		.mst_s_rlast(mst_s_rlast),
		.mst_s_rvalid(mst_s_rvalid),
		.mst_s_rready(mst_s_rready),
		.cmd_id(cmd_id),
		.cmd_len(cmd_len),
		.cmd_addr(cmd_addr),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.resp_id(resp_id),
		.resp_len(resp_len),
		.resp_err(resp_err),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.data_din(data_din),
		.data_valid(data_valid),
		.data_ready(data_ready)
	);

	pci_read_sequencer seq_i (
		.clk(clk),
		.mst_s_aresetn(mst_s_aresetn),
		.cmd_id(cmd_id),
		.cmd_len(cmd_len),
		.cmd_addr(cmd_addr),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.data_din(data_din),
		.data_valid(data_valid),
		.data_ready(data_ready),
		.resp_id(resp_id),
		.resp_len(resp_len),
		.resp_err(resp_err),
		.resp_valid(resp_valid),
		.resp_ready(resp_ready),
		.tgt_addr(tgt_addr),
		.tgt_req(tgt_req),
		.tgt_ack(tgt_ack),
		.tgt_rdata(tgt_rdata),
		.tgt_err(tgt_err)
	);

endmodule

// File: dv/pci_master_read_tests.svh
`ifndef PCI_MASTER_READ_TESTS_SVH
`define PCI_MASTER_READ_TESTS_SVH

// queue the expected burst, then hold arvalid until the handshake
task automatic issue_read(input logic [pci_master_pkg::ID_W-1:0] id,
	input logic [pci_master_pkg::ADDR_W-1:0] addr,
	input logic [pci_master_pkg::LEN_W-1:0] len);
	burst_t b;
	b.id = id;
	b.addr = addr;
	b.len = len;
	b.resp = pci_master_pkg::RESP_OKAY;
	for (int i = 0; i <= int'(len); i++) begin
		if (in_err_window(addr + 64'(4 * i)))
			b.resp = pci_master_pkg::RESP_SLVERR;
	end
	exp_q.push_back(b);
	mst_s_arid = id;
	mst_s_araddr = addr;
	mst_s_arlen = len;
	mst_s_arvalid = 1'b1;
	while (!mst_s_arready)
		@(negedge clk);
	@(negedge clk);
	mst_s_arvalid = 1'b0;
endtask

task automatic wait_drain();
	while (exp_q.size() != 0)
		@(negedge clk);
	repeat (20) @(negedge clk); // a stray beat would show up here
endtask

task automatic test_reset_state();
	repeat (4) begin
		@(negedge clk);
		check_flag(mst_s_arready, 1'b1, "arready in reset");
		check_flag(mst_s_rvalid, 1'b0, "rvalid in reset");
		check_flag(tgt_req, 1'b0, "tgt_req in reset");
	end
	mst_s_aresetn = 1'b1;
	@(negedge clk);
	check_flag(mst_s_arready, 1'b1, "arready after reset");
	check_flag(mst_s_rvalid, 1'b0, "rvalid after reset");
	check_flag(tgt_req, 1'b0, "tgt_req after reset");
endtask

task automatic test_single_beat();
	issue_read(4'h3, 64'h40, 8'd0);
	wait_drain();
endtask

task automatic test_multi_beat();
	issue_read(4'h5, 64'h100, 8'd15);
	wait_drain();
endtask

task automatic test_error_status();
	issue_read(4'h9, 64'h80f8, 8'd7); // first two dwords inside the window
	issue_read(4'ha, 64'h8200, 8'd3);
	wait_drain();
endtask

task automatic test_backpressure_order();
	long_stalls = 1'b1;
	saw_data_full = 1'b0;
	stall_left = 700; // rready low until the data fifo backs up
	for (int i = 0; i < 8; i++)
		issue_read(4'(i + 1), 64'h2000 + 64'(i * 64'h40), 8'(8 + $urandom % 8));
	wait_drain();
	long_stalls = 1'b0;
	if (!saw_data_full) begin
		other_errs++;
		$display("ERROR @%0t: data FIFO never filled under back-pressure", $time);
	end
endtask

`endif

// File: dv/pci_master_read_tb.sv
`timescale 1ns/1ns

module pci_master_read_tb;

	localparam int CLK_PERIOD = 100;
	localparam int MAX_BEATS = 1 + 16 + 8 + 4 + 8 * 16; // upper bound over all tests

	typedef struct packed {
		logic [pci_master_pkg::ID_W-1:0] id;
		logic [pci_master_pkg::ADDR_W-1:0] addr;
		logic [pci_master_pkg::LEN_W-1:0] len;
		logic [pci_master_pkg::RESP_W-1:0] resp;
	} burst_t;

	logic clk;
	logic mst_s_aresetn;
	logic [pci_master_pkg::ID_W-1:0] mst_s_arid;
	logic [pci_master_pkg::ADDR_W-1:0] mst_s_araddr;
	logic [pci_master_pkg::LEN_W-1:0] mst_s_arlen;
	logic [2:0] mst_s_arsize;
	logic [1:0] mst_s_arburst;
	logic [3:0] mst_s_arcache;
	logic mst_s_arvalid;
	logic mst_s_arready;
	logic [pci_master_pkg::ID_W-1:0] mst_s_rid;
	logic [pci_master_pkg::DATA_W-1:0] mst_s_rdata;
	logic [pci_master_pkg::RESP_W-1:0] mst_s_rresp;
	logic mst_s_rlast;
	logic mst_s_rvalid;
	logic mst_s_rready;
	logic [pci_master_pkg::ADDR_W-1:0] tgt_addr;
	logic tgt_req;
	logic tgt_ack;
	logic [pci_master_pkg::DATA_W-1:0] tgt_rdata;
	logic tgt_err;

	burst_t exp_q[$]; // bursts still owed on the R channel
	int beat_idx = 0;
	int ack_wait = 0;
	int stall_left = 0;
	bit long_stalls = 0;
	bit saw_data_full = 0;
	int data_errs = 0;
	int resp_errs = 0;
	int id_errs = 0;
	int last_errs = 0;
	int other_errs = 0;

	pci_master_read_top #(.CMD_AW(4), .DATA_AW(6)) dut (.*);

	function automatic logic [pci_master_pkg::DATA_W-1:0] model_data(
		input logic [pci_master_pkg::ADDR_W-1:0] a);
		return a[31:0] ^ 32'h5a5a0000;
	endfunction

	function automatic bit in_err_window(input logic [pci_master_pkg::ADDR_W-1:0] a);
		return (a >= 64'h8000) && (a <= 64'h80ff);
	endfunction

	task automatic check_data(input logic [pci_master_pkg::DATA_W-1:0] got,
		input logic [pci_master_pkg::DATA_W-1:0] exp, input string what);
		if (got !== exp) begin
			data_errs++;
			$display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic [pci_master_pkg::RESP_W-1:0] got,
		input logic [pci_master_pkg::RESP_W-1:0] exp, input string what);
		if (got !== exp) begin
			resp_errs++;
			$display("CHECK FAILED @%0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_id(input logic [pci_master_pkg::ID_W-1:0] got,
		input logic [pci_master_pkg::ID_W-1:0] exp, input string what);
		if (got !== exp) begin
			id_errs++;
			$display("CHECK FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			last_errs++;
			$display("CHECK FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			other_errs++;
			$display("CHECK FAILED @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic score_beat();
		burst_t b;
		logic [pci_master_pkg::ADDR_W-1:0] a;
		if (exp_q.size() == 0) begin
			other_errs++;
			$display("ERROR @%0t: R beat arrived with no burst outstanding", $time);
		end else begin
			b = exp_q[0];
			a = b.addr + 64'(4 * beat_idx);
			check_data(mst_s_rdata, model_data(a), "rdata");
			check_resp(mst_s_rresp, b.resp, "rresp");
			check_id(mst_s_rid, b.id, "rid");
			check_last(mst_s_rlast, beat_idx == int'(b.len), "rlast");
			if (beat_idx == int'(b.len)) begin
				void'(exp_q.pop_front());
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
	endtask

	`include "pci_master_read_tests.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// target memory answering each request after a random wait
	initial begin : target_model
		forever begin
			@(negedge clk);
			if (!mst_s_aresetn || tgt_ack) begin
				tgt_ack = 1'b0;
			end else if (tgt_req) begin
				if (ack_wait == 0) begin
					tgt_ack = 1'b1;
					tgt_rdata = model_data(tgt_addr);
					tgt_err = in_err_window(tgt_addr);
					ack_wait = $urandom % 6;
				end else begin
					ack_wait--;
				end
			end
		end
	end

	initial begin : r_monitor
		forever begin
			@(negedge clk);
			if (!mst_s_aresetn) begin
				mst_s_rready = 1'b0;
			end else if (stall_left > 0) begin
				mst_s_rready = 1'b0;
				stall_left--;
			end else if (long_stalls && ($urandom % 8) == 0) begin
				mst_s_rready = 1'b0;
				stall_left = 50 + $urandom % 250;
			end else begin
				mst_s_rready = 1'b1;
			end
			if (mst_s_aresetn && !dut.data_ready)
				saw_data_full = 1'b1;
			if (mst_s_rvalid && mst_s_rready)
				score_beat(); // transfer lands on the coming rising edge
		end
	end

	initial begin : watchdog
		#(CLK_PERIOD * (200 * MAX_BEATS + 2000));
		$display("TIMEOUT: bursts did not complete in time, %0d still outstanding",
			exp_q.size());
		$display("Simulation failed");
		$finish;
	end

	initial begin : main_seq
		int total;
		void'($urandom(32'hdaba8924));
		mst_s_aresetn = 1'b0;
		mst_s_arid = '0;
		mst_s_araddr = '0;
		mst_s_arlen = '0;
		mst_s_arsize = 3'd2; // 32-bit beats
		mst_s_arburst = 2'b01; // incr
		mst_s_arcache = '0;
		mst_s_arvalid = 1'b0;
		mst_s_rready = 1'b0;
		tgt_ack = 1'b0;
		tgt_rdata = '0;
		tgt_err = 1'b0;
		test_reset_state();
		test_single_beat();
		test_multi_beat();
		test_error_status();
		test_backpressure_order();
		total = data_errs + resp_errs + id_errs + last_errs + other_errs;
		$display("errors: data %0d, resp %0d, id %0d, last %0d, other %0d",
			data_errs, resp_errs, id_errs, last_errs, other_errs);
		if (total == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: pci_master_read_top.f
+incdir+dv
source/pci_master_pkg.sv
source/sync_fifo.sv
source/pci_read_sequencer.sv
source/pci_master_rpath.sv
source/pci_master_read_top.sv
dv/pci_master_read_tb.sv

// File: Bender.yml
package:
  name: pci_master_read

sources:
  - source/pci_master_pkg.sv
  - source/sync_fifo.sv
  - source/pci_read_sequencer.sv
  - source/pci_master_rpath.sv
  - source/pci_master_read_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/pci_master_read_tb.sv
